/* Bender.yml */
package:
  name: main_board

dependencies: {}

sources:
  - source/main_pkg.sv
  - source/main_ctrl.sv
  - source/cabinet_ports.sv
  - source/main_rdmux.sv
  - source/main_board.sv
  - target: test
    files:
      - test/main_board_tb.sv

/* main_board.f */
source/main_pkg.sv
source/main_ctrl.sv
source/cabinet_ports.sv
source/main_rdmux.sv
source/main_board.sv
test/main_board_tb.sv

/* source/cabinet_ports.sv */
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// cabinet input ports
// remapped joystick byte per player and the system port
//////////////////////////////////////////////////////////////////////
module cabinet_ports import main_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       addr_lsb,
    input  cab_in_t    cab_in,
    output logic [7:0] cab_dout,
    output logic [7:0] sys_dout
);

    logic [5:0] joy_sel;
    logic [7:0] joy_byte;

    // board wiring swaps the direction pairs
    function automatic logic [7:0] remap_joy(input logic [5:0] joy);
        logic [7:0] b;
        b = {2'b11, joy[5:4], joy[2], joy[3], joy[0], joy[1]};
        return b;
    endfunction

    assign joy_sel  = addr_lsb ? cab_in.joy1 : cab_in.joy2; // odd address is player 1
    assign joy_byte = remap_joy(joy_sel);

    // one cycle late, read on the second bus cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            cab_dout <= OPEN_BUS;
        end else begin
            cab_dout <= joy_byte;
        end
    end

    // upper bits float high
    assign sys_dout = {5'b11111, cab_in.service, cab_in.coin};

endmodule

/* source/main_board.sv */
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// main cpu board, bus side
// decode and banking, cabinet ports and the cpu read bus
//////////////////////////////////////////////////////////////////////
module main_board import main_pkg::*; #(
    parameter int BANK_W = 3
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               cpu_cen,
    input  bus_req_t           bus_req,
    input  cab_in_t            cab_in,
    // rom
    input  logic [7:0]         rom_data,
    input  logic               rom_ok,
    output logic [BANK_W+13:0] rom_addr,
    output logic               rom_cs,
    // work ram and palette
    input  logic [7:0]         ram_dout,
    input  logic [7:0]         pal_dout,
    output logic               ram_cs,
    output logic               pal_cs,
    // graphics chip
    input  logic [7:0]         gfx_dout,
    input  logic               gfx_irqn,
    output logic               gfx_cs,
    output logic [12:0]        gfx_addr,
    // cpu side
    input  logic               dip_pause,
    input  logic               irq_ack,
    output logic [7:0]         cpu_din,
    output logic               irq_n
);

    chip_sel_t  sel;
    logic [7:0] cab_dout;
    logic [7:0] sys_dout;

    assign ram_cs = sel.ram;
    assign pal_cs = sel.pal;

    main_ctrl #(
        .BANK_W (BANK_W)
    ) main_ctrl_inst (
        .clk       (clk),
        .rst       (rst),
        .cpu_cen   (cpu_cen),
        .bus_req   (bus_req),
        .gfx_irqn  (gfx_irqn),
        .dip_pause (dip_pause),
        .irq_ack   (irq_ack),
        .sel       (sel),
        .rom_cs    (rom_cs),
        .rom_addr  (rom_addr),
        .gfx_cs    (gfx_cs),
        .gfx_addr  (gfx_addr),
        .irq_n     (irq_n)
    );

    cabinet_ports cabinet_ports_inst (
        .clk      (clk),
        .rst      (rst),
        .addr_lsb (bus_req.addr[0]),
        .cab_in   (cab_in),
        .cab_dout (cab_dout),
        .sys_dout (sys_dout)
    );

    main_rdmux main_rdmux_inst (
        .sel      (sel),
        .cab_dout (cab_dout),
        .sys_dout (sys_dout),
        .rom_data (rom_data),
        .ram_dout (ram_dout),
        .pal_dout (pal_dout),
        .gfx_dout (gfx_dout),
        .cpu_din  (cpu_din)
    );

endmodule

/* source/main_ctrl.sv */
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// main cpu bus control
// address decode, rom banking, graphics select and irq latch
//////////////////////////////////////////////////////////////////////
module main_ctrl import main_pkg::*; #(
    parameter int BANK_W = 3
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               cpu_cen,
    input  bus_req_t           bus_req,
    input  logic               gfx_irqn,
    input  logic               dip_pause,
    input  logic               irq_ack,
    output chip_sel_t          sel,
    output logic               rom_cs,
    output logic [BANK_W+13:0] rom_addr,
    output logic               gfx_cs,
    output logic [12:0]        gfx_addr,
    output logic               irq_n
);

    localparam int ROM_AW = BANK_W + 14;

    logic              bank_we;
    logic              io_page;
    logic              gfx_win;
    logic [BANK_W-1:0] bank;
    logic [BANK_W:0]   bank_ofs;
    logic              irq_trig;
    logic              irq_trig_q;
    logic              irq_edge;

    always_comb begin
        sel     = '0;
        bank_we = 1'b0;
        gfx_win = bus_req.addr[15:13] == 3'b001;   // 2000-3FFF
        io_page = bus_req.addr[15:11] == 5'b00001; // 0800-0FFF
        sel.rom = (bus_req.addr[15] || bus_req.addr[15:14] == 2'b01) && bus_req.rnw;
        sel.ram = bus_req.addr[15:11] == 5'b00011; // 1800-1FFF
        sel.pal = bus_req.addr[15:11] == 5'b00010; // 1000-17FF
        // chip registers sit in page zero as well
        sel.gfx = gfx_win || bus_req.addr[15:8] == 8'h00;
        if (io_page) begin
            case (bus_req.addr[10:8])
                IO_SND0, IO_SND1: sel.snd = 1'b1;
                IO_INP:  sel.inp  = bus_req.rnw;
                IO_SYS:  sel.sys  = bus_req.rnw;
                IO_BANK: bank_we  = !bus_req.rnw;
                IO_PROT: sel.prot = 1'b1;
                default: ; // watchdog page, nothing here
            endcase
        end
    end

    assign rom_cs = sel.rom;

    // banked window starts at 0x8000 in the rom image
    assign bank_ofs = {1'b0, bank} + (BANK_W+1)'(4);
    assign rom_addr = bus_req.addr[15] ? ROM_AW'(bus_req.addr[ROM_FIXED_W-1:0])
                                       : {bank_ofs, bus_req.addr[12:0]};

    always_ff @(posedge clk) begin
        if (rst) begin
            bank <= '0;
        end else if (cpu_cen && bank_we) begin
            bank <= bus_req.dout[BANK_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            gfx_cs <= 1'b0;
        end else begin
            gfx_cs <= sel.gfx;
        end
    end

    // top bit flags the 2xxx half of the window
    always_ff @(posedge clk) begin
        gfx_addr <= {gfx_win & ~bus_req.addr[12], bus_req.addr[11:0]};
    end

    // irq latch, set on the trigger edge
    assign irq_trig = ~gfx_irqn & dip_pause;
    assign irq_edge = irq_trig & ~irq_trig_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            irq_trig_q <= 1'b0;
            irq_n      <= 1'b1;
        end else begin
            irq_trig_q <= irq_trig;
            if (irq_edge) begin
                irq_n <= 1'b0; // edge beats a same cycle ack
            end else if (irq_ack) begin
                irq_n <= 1'b1;
            end
        end
    end

    sel_onehot_a: assert property (
        @(posedge clk) disable iff (rst) $onehot0(sel)
    );

    // bank only moves after a strobed write cycle
    bank_write_a: assert property (
        @(posedge clk) disable iff (rst)
        !$stable(bank) |-> $past(cpu_cen && bank_we && !bus_req.rnw)
    );

endmodule

/* source/main_pkg.sv */
//////////////////////////////////////////////////////////////////////
// main board shared types
// bus cycle, chip select set and cabinet input bundle
//////////////////////////////////////////////////////////////////////
package main_pkg;

    // one cpu bus cycle as the master drives it
    typedef struct packed {
        logic [15:0] addr;
        logic        rnw;   // 1 = read
        logic [7:0]  dout;  // write data
    } bus_req_t;

    // decoded selects, never more than one set
    typedef struct packed {
        logic rom;
        logic ram;
        logic pal;
        logic gfx;   // unregistered
        logic inp;
        logic sys;
        logic snd;
        logic prot;
    } chip_sel_t;

    // cabinet controls, all active low
    typedef struct packed {
        logic [1:0] start;
        logic [1:0] coin;
        logic [5:0] joy1;
        logic [5:0] joy2;
        logic       service;
    } cab_in_t;

    // floating data bus
    localparam logic [7:0] OPEN_BUS = 8'hff;

    // 8000-FFFF maps straight through
    localparam int ROM_FIXED_W = 15;

    // 256 byte pages inside 0800-0FFF, by addr[10:8]
    localparam logic [2:0] IO_SND0 = 3'd0;
    localparam logic [2:0] IO_SND1 = 3'd1;
    localparam logic [2:0] IO_INP  = 3'd2;
    localparam logic [2:0] IO_SYS  = 3'd3;
    localparam logic [2:0] IO_BANK = 3'd4;
    localparam logic [2:0] IO_PROT = 3'd5;

endpackage

/* source/main_rdmux.sv */
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// cpu read data mux
// fixed priority over the decoded selects
//////////////////////////////////////////////////////////////////////
module main_rdmux import main_pkg::*; (
    input  chip_sel_t  sel,
    input  logic [7:0] cab_dout,
    input  logic [7:0] sys_dout,
    input  logic [7:0] rom_data,
    input  logic [7:0] ram_dout,
    input  logic [7:0] pal_dout,
    input  logic [7:0] gfx_dout,
    output logic [7:0] cpu_din
);

    logic [7:0] port_dout;

    // inp and sys share one slot in the priority order
    assign port_dout = sel.inp ? cab_dout : sys_dout;

    always_comb begin
        case (1'b1)
            sel.rom:           cpu_din = rom_data;
            sel.ram:           cpu_din = ram_dout;
            sel.pal:           cpu_din = pal_dout;
            sel.inp, sel.sys:  cpu_din = port_dout;
            sel.gfx:           cpu_din = gfx_dout;
            default:           cpu_din = OPEN_BUS; // snd, prot, unmapped
        endcase
    end

    // a selected source must drive the bus
    always_comb begin
        if (|sel) begin
            din_known_a: assert final (!$isunknown(cpu_din));
        end
    end

endmodule

/* test/main_board_cases.txt */
// kind pause addr wdata cab_in rom ram pal gfx, then expected cpu_din rom_addr rom_cs
// gfx_cs gfx_addr irq_n; kind 0 read, 1 write, 2 irq trigger, 3 irq ack, f end
// after reset, bank 0 and the fixed window
0 1 4000 00 1d4ad 5a a5 3c c3  5a 08000 1 0 0000 1
0 1 8000 00 1d4ad 5a a5 3c c3  5a 00000 1 0 0000 1
0 1 ffff 00 1d4ad 96 a5 3c c3  96 07fff 1 0 0000 1
0 1 5abc 00 1d4ad 5a a5 3c c3  5a 09abc 1 0 0000 1
0 1 7fff 00 1d4ad 5a a5 3c c3  5a 09fff 1 0 0000 1
// work ram and palette
0 1 1800 00 1d4ad 5a a5 3c c3  a5 00000 0 0 0000 1
0 1 1fff 00 1d4ad 5a 69 3c c3  69 00000 0 0 0000 1
0 1 1000 00 1d4ad 5a a5 3c c3  3c 00000 0 0 0000 1
0 1 17ff 00 1d4ad 5a a5 81 c3  81 00000 0 0 0000 1
// graphics window and page zero registers
0 1 2000 00 1d4ad 5a a5 3c c3  c3 00000 0 1 1000 1
0 1 2abc 00 1d4ad 5a a5 3c c3  c3 00000 0 1 1abc 1
0 1 2fff 00 1d4ad 5a a5 3c c3  c3 00000 0 1 1fff 1
0 1 3000 00 1d4ad 5a a5 3c c3  c3 00000 0 1 0000 1
0 1 3fff 00 1d4ad 5a a5 3c 42  42 00000 0 1 0fff 1
0 1 0055 00 1d4ad 5a a5 3c c3  c3 00000 0 1 0055 1
0 1 00ff 00 1d4ad 5a a5 3c c3  c3 00000 0 1 00ff 1
// sound, protection, watchdog and unmapped pages read open bus
0 1 0800 00 1d4ad 5a a5 3c c3  ff 00000 0 0 0000 1
0 1 0900 00 1d4ad 5a a5 3c c3  ff 00000 0 0 0000 1
0 1 0d00 00 1d4ad 5a a5 3c c3  ff 00000 0 0 0000 1
0 1 0e00 00 1d4ad 5a a5 3c c3  ff 00000 0 0 0000 1
0 1 0100 00 1d4ad 5a a5 3c c3  ff 00000 0 0 0000 1
0 1 0700 00 1d4ad 5a a5 3c c3  ff 00000 0 0 0000 1
0 1 0c00 00 1d4ad 5a a5 3c c3  ff 00000 0 0 0000 1
// cabinet ports, even address player 2, odd player 1
0 1 0a00 00 1d4ad 5a a5 3c c3  d9 00000 0 0 0000 1
0 1 0a01 00 1d4ad 5a a5 3c c3  e6 00000 0 0 0000 1
0 1 0b00 00 1d4ad 5a a5 3c c3  fe 00000 0 0 0000 1
0 1 0a00 00 023f0 5a a5 3c c3  f4 00000 0 0 0000 1
0 1 0a01 00 023f0 5a a5 3c c3  cb 00000 0 0 0000 1
0 1 0b00 00 023f0 5a a5 3c c3  f9 00000 0 0 0000 1
// bank switching and writes
1 1 0c00 0b 1d4ad 5a a5 3c c3  ff 00000 0 0 0000 1
0 1 4000 00 1d4ad 5a a5 3c c3  5a 0e000 1 0 0000 1
0 1 6123 00 1d4ad 5a a5 3c c3  5a 0e123 1 0 0000 1
0 1 c123 00 1d4ad 5a a5 3c c3  5a 04123 1 0 0000 1
1 1 0c00 05 1d4ad 5a a5 3c c3  ff 00000 0 0 0000 1
0 1 7fff 00 1d4ad 5a a5 3c c3  5a 13fff 1 0 0000 1
1 1 8000 77 1d4ad 5a a5 3c c3  ff 00000 0 0 0000 1
1 1 1800 77 1d4ad 5a a5 3c c3  a5 00000 0 0 0000 1
1 1 2100 77 1d4ad 5a a5 3c c3  c3 00000 0 1 1100 1
1 1 0a00 77 1d4ad 5a a5 3c c3  ff 00000 0 0 0000 1
1 1 0c00 ff 1d4ad 5a a5 3c c3  ff 00000 0 0 0000 1
0 1 4000 00 1d4ad 5a a5 3c c3  5a 16000 1 0 0000 1
// interrupt latch, pause low blocks the trigger
2 0 0100 00 1d4ad 5a a5 3c c3  ff 00000 0 0 0000 1
0 1 0100 00 1d4ad 5a a5 3c c3  ff 00000 0 0 0000 1
2 1 0100 00 1d4ad 5a a5 3c c3  ff 00000 0 0 0000 0
0 1 8000 00 1d4ad 5a a5 3c c3  5a 00000 1 0 0000 0
3 1 0100 00 1d4ad 5a a5 3c c3  ff 00000 0 0 0000 1
0 1 0100 00 1d4ad 5a a5 3c c3  ff 00000 0 0 0000 1
f 0 0000 00 00000 00 00 00 00  00 00000 0 0 0000 0

/* test/main_board_tb.sv */
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// main board testbench
// bus master replayed from the case file, results checked per case
//////////////////////////////////////////////////////////////////////
module main_board_tb import main_pkg::*; ();

    localparam int BANK_W    = 3;
    localparam int NUM_COLS  = 15;
    localparam int MAX_CASES = 64;

    // operation kinds, first column of the case file
    localparam logic [3:0] OP_READ  = 4'h0;
    localparam logic [3:0] OP_WRITE = 4'h1;
    localparam logic [3:0] OP_IRQ   = 4'h2;
    localparam logic [3:0] OP_ACK   = 4'h3;
    localparam logic [3:0] OP_END   = 4'hf;

    logic               clk;
    logic               rst;
    logic               cpu_cen;
    bus_req_t           bus_req;
    cab_in_t            cab_in;
    logic [7:0]         rom_data;
    logic               rom_ok;
    logic [BANK_W+13:0] rom_addr;
    logic               rom_cs;
    logic [7:0]         ram_dout;
    logic [7:0]         pal_dout;
    logic               ram_cs;
    logic               pal_cs;
    logic [7:0]         gfx_dout;
    logic               gfx_irqn;
    logic               gfx_cs;
    logic [12:0]        gfx_addr;
    logic               dip_pause;
    logic               irq_ack;
    logic [7:0]         cpu_din;
    logic               irq_n;

    logic [31:0] case_mem [0:NUM_COLS*MAX_CASES-1];
    int          num_cases;
    int          case_idx;   // shown on error lines, -1 for the reset check
    int          errors;
    int          cycle_count;
    int          cycle_limit;

    main_board #(
        .BANK_W (BANK_W)
    ) main_board_inst (
        .clk       (clk),
        .rst       (rst),
        .cpu_cen   (cpu_cen),
        .bus_req   (bus_req),
        .cab_in    (cab_in),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .rom_addr  (rom_addr),
        .rom_cs    (rom_cs),
        .ram_dout  (ram_dout),
        .pal_dout  (pal_dout),
        .ram_cs    (ram_cs),
        .pal_cs    (pal_cs),
        .gfx_dout  (gfx_dout),
        .gfx_irqn  (gfx_irqn),
        .gfx_cs    (gfx_cs),
        .gfx_addr  (gfx_addr),
        .dip_pause (dip_pause),
        .irq_ack   (irq_ack),
        .cpu_din   (cpu_din),
        .irq_n     (irq_n)
    );

    always #4 clk = ~clk;

    // run limit, counted in clocks
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, the case sequence never finished", cycle_count);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("FAILED case %0d %s: got %h, expected %h", case_idx, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_cs(input string name, input logic got, exp);
        if (got !== exp) begin
            $display("FAILED case %0d %s: got %h, expected %h", case_idx, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_rom(input logic [BANK_W+13:0] got_addr, exp_addr,
                             input logic got_cs, exp_cs);
        if (got_cs !== exp_cs) begin
            $display("FAILED case %0d rom_cs: got %h, expected %h", case_idx, got_cs, exp_cs);
            errors++;
        end
        if (exp_cs && got_addr !== exp_addr) begin
            $display("FAILED case %0d rom_addr: got %h, expected %h",
                     case_idx, got_addr, exp_addr);
            errors++;
        end
    endtask

    task automatic check_gfx(input logic got_cs, exp_cs,
                             input logic [12:0] got_addr, exp_addr);
        if (got_cs !== exp_cs) begin
            $display("FAILED case %0d gfx_cs: got %h, expected %h", case_idx, got_cs, exp_cs);
            errors++;
        end
        if (exp_cs && got_addr !== exp_addr) begin
            $display("FAILED case %0d gfx_addr: got %h, expected %h",
                     case_idx, got_addr, exp_addr);
            errors++;
        end
    endtask

    task automatic check_irq(input logic got, exp);
        if (got !== exp) begin
            $display("FAILED case %0d irq_n: got %h, expected %h", case_idx, got, exp);
            errors++;
        end
    endtask

    // one bus operation, two cycles with the strobe on the first
    task automatic run_case(input int idx);
        int         base;
        logic [3:0] kind;
        bus_req_t   req;
        logic       exp_ram;
        logic       exp_pal;
        base     = idx * NUM_COLS;
        kind     = case_mem[base][3:0];
        req.addr = case_mem[base+2][15:0];
        req.rnw  = kind != OP_WRITE;
        req.dout = case_mem[base+3][7:0];
        // work ram 1800-1FFF and palette 1000-17FF, reads and writes alike
        exp_ram  = req.addr >= 16'h1800 && req.addr <= 16'h1fff;
        exp_pal  = req.addr >= 16'h1000 && req.addr <= 16'h17ff;
        case (kind)
            OP_READ, OP_WRITE, OP_IRQ, OP_ACK: ;
            default: begin
                $display("case %0d has an unknown operation kind %h", idx, kind);
                errors++;
            end
        endcase
        @(posedge clk);
        cpu_cen   <= 1'b1;
        bus_req   <= req;
        cab_in    <= cab_in_t'(case_mem[base+4][16:0]);
        rom_data  <= case_mem[base+5][7:0];
        ram_dout  <= case_mem[base+6][7:0];
        pal_dout  <= case_mem[base+7][7:0];
        gfx_dout  <= case_mem[base+8][7:0];
        dip_pause <= case_mem[base+1][0];
        gfx_irqn  <= kind != OP_IRQ;   // held low for the whole operation
        irq_ack   <= kind == OP_ACK;
        @(posedge clk);
        cpu_cen <= 1'b0;
        irq_ack <= 1'b0;
        @(negedge clk);   // second cycle, registered outputs settled
        check_byte("cpu_din", cpu_din, case_mem[base+9][7:0]);
        check_rom(rom_addr, case_mem[base+10][BANK_W+13:0], rom_cs, case_mem[base+11][0]);
        check_cs("ram_cs", ram_cs, exp_ram);
        check_cs("pal_cs", pal_cs, exp_pal);
        check_gfx(gfx_cs, case_mem[base+12][0], gfx_addr, case_mem[base+13][12:0]);
        check_irq(irq_n, case_mem[base+14][0]);
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        cpu_cen     = 1'b0;
        bus_req     = '{addr: 16'h2000, rnw: 1'b1, dout: 8'h00}; // gfx window during reset
        cab_in      = '1;   // controls idle high
        rom_data    = 8'h00;
        rom_ok      = 1'b1;
        ram_dout    = 8'h00;
        pal_dout    = 8'h00;
        gfx_dout    = 8'h00;
        gfx_irqn    = 1'b1;
        dip_pause   = 1'b1;
        irq_ack     = 1'b0;
        errors      = 0;
        cycle_count = 0;
        num_cases   = 0;
        case_idx    = -1;

        $readmemh("test/main_board_cases.txt", case_mem);
        while (num_cases < MAX_CASES && !$isunknown(case_mem[num_cases*NUM_COLS])
               && case_mem[num_cases*NUM_COLS][3:0] != OP_END) begin
            num_cases = num_cases + 1;
        end
        cycle_limit = 4 * num_cases * 2 + 100;

        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_gfx(gfx_cs, 1'b0, gfx_addr, 13'h0000);
        check_irq(irq_n, 1'b1);

        if (num_cases == 0) begin
            $display("no cases could be read from test/main_board_cases.txt");
            errors++;
        end
        for (int i = 0; i < num_cases; i++) begin
            case_idx = i;
            run_case(i);
        end

        $display("%0d errors over %0d cases", errors, num_cases);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
